/* common/lpif_neg_pkg.sv */
/* Shared widths, control-field layout and encodings for the protocol negotiation block.
   One build only: a 256-bit data path carrying four 64-bit replicated slots. */

package lpif_neg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data path geometry

  // Full width of the upstream and downstream buses
  localparam int DATA_WIDTH = 256;

  // One replicated slot when the bus carries the default four slots
  localparam int SLOT_WIDTH = 64;

  //////////////////////////////////////////////////////////////////////
  // Control field layout at the bottom of every slot

  localparam int REQ_LOC    = 0;
  localparam int ACK_LOC    = 1;
  localparam int PROT_LOC   = 2;
  localparam int PROT_WIDTH = 3;
  localparam int CTL_WIDTH  = 5;

  // Protocol codes exchanged during negotiation
  // Codes 1 and 2 are not defined and make the result invalid
  typedef enum logic [PROT_WIDTH-1:0] {
    PROT_NONE     = 3'd0,
    CXL11_SINGLE  = 3'd3,
    CXL11_MULTI   = 3'd4,
    CXL20_MULTI12 = 3'd5,
    CXL20_MULTI3  = 3'd6,
    CXL20_SINGLE  = 3'd7
  } prot_e;

  // Negotiation states
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_W4ACK  = 3'd1,
    ST_NEG    = 3'd2,
    ST_W4NACK = 3'd3,
    ST_QUIET1 = 3'd4,
    ST_QUIET2 = 3'd5,
    ST_DONE   = 3'd6
  } neg_state_e;

  // Control field as it sits in a slot, req in the lowest bit
  typedef struct packed {
    prot_e prot;
    logic  ack;
    logic  req;
  } neg_ctl_t;

endpackage

/* hw/neg_fsm.sv */
/* Request/acknowledge negotiation with the remote die, one exchange in flight at a time.
   The remote side may stall the machine in ST_W4ACK or ST_W4NACK without limit. */

`timescale 1ns/1ps

module neg_fsm #(
  parameter lpif_neg_pkg::prot_e LOCAL_PROT = lpif_neg_pkg::CXL11_MULTI
) (
  input  logic                    lclk,
  input  logic                    reset,
  input  logic                    ctl_link_up,
  input  logic                    renegotiate_n,
  input  lpif_neg_pkg::neg_ctl_t  rmote_ctl,
  output lpif_neg_pkg::neg_ctl_t  local_ctl,
  output lpif_neg_pkg::neg_state_e neg_state,
  output logic                    negotiation_link_up
);

  import lpif_neg_pkg::*;

  neg_state_e state_q;
  neg_state_e state_d;
  logic       ack_window;

  //////////////////////////////////////////////////////////////////////
  // State register and next state

  always_ff @(posedge lclk or negedge reset) begin
    if (!reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (ctl_link_up && renegotiate_n) state_d = ST_W4ACK;
      end
      // Wait until the remote side both requests and acknowledges ours
      ST_W4ACK: begin
        if (rmote_ctl.req && rmote_ctl.ack) state_d = ST_NEG;
      end
      ST_NEG: state_d = ST_W4NACK;
      // Wait until the remote side has dropped both req and ack
      ST_W4NACK: begin
        if (!rmote_ctl.req && !rmote_ctl.ack) state_d = ST_QUIET1;
      end
      // Two quiet cycles so the remote side is sure to see our ack low
      ST_QUIET1: state_d = ST_QUIET2;
      ST_QUIET2: state_d = ST_DONE;
      ST_DONE: begin
        if (!renegotiate_n) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Local control field

  // Our ack follows the remote req for the whole exchange
  assign ack_window = state_q inside {ST_W4ACK, ST_NEG, ST_W4NACK, ST_QUIET1, ST_QUIET2};

  always_comb begin
    local_ctl      = '0;
    local_ctl.prot = LOCAL_PROT;
    local_ctl.req  = (state_q == ST_W4ACK) || (state_q == ST_NEG);
    local_ctl.ack  = ack_window & rmote_ctl.req;
  end

  assign neg_state           = state_q;
  assign negotiation_link_up = (state_q == ST_DONE);

endmodule

/* hw/prot_resolve.sv */
/* Resolves local and remote protocol codes into the agreed protocol, captured in ST_NEG.
   Codes outside 3..7 on either side give pl_protocol_vld low with a fallback code of 3. */

`timescale 1ns/1ps

module prot_resolve #(
  parameter lpif_neg_pkg::prot_e LOCAL_PROT = lpif_neg_pkg::CXL11_MULTI,
  parameter bit                  IS_HOST    = 1'b0
) (
  input  logic                     lclk,
  input  logic                     reset,
  input  lpif_neg_pkg::neg_state_e neg_state,
  input  lpif_neg_pkg::prot_e      rmote_prot,
  input  logic                     renegotiate_n,
  input  logic                     ctl_link_up,
  output lpif_neg_pkg::prot_e      pl_protocol,
  output logic                     pl_protocol_vld,
  output logic                     pl_inband_pres,
  output logic                     pl_portmode,
  output logic                     pl_portmode_val
);

  import lpif_neg_pkg::*;

  prot_e host_prot;
  prot_e device_prot;
  prot_e res_prot;
  logic  res_vld;
  logic  portmode_q;

  function automatic logic code_known(input prot_e code);
    return code >= CXL11_SINGLE;
  endfunction

  assign host_prot   = IS_HOST ? LOCAL_PROT : rmote_prot;
  assign device_prot = IS_HOST ? rmote_prot : LOCAL_PROT;

  //////////////////////////////////////////////////////////////////////
  // Resolution table
  //
  // CXL 1.1 single on either side wins outright
  // CXL 2.0 single against CXL 1.1 multi falls back to CXL 1.1 single
  // Otherwise CXL 1.1 multi wins, then a CXL 2.0 single host,
  // and in every remaining case the device choice stands

  always_comb begin
    res_vld  = 1'b1;
    res_prot = CXL11_SINGLE;
    if (!code_known(host_prot) || !code_known(device_prot)) begin
      res_vld = 1'b0;
    end else if (host_prot == CXL11_SINGLE || device_prot == CXL11_SINGLE) begin
      res_prot = CXL11_SINGLE;
    end else if ((host_prot == CXL20_SINGLE && device_prot == CXL11_MULTI) ||
                 (host_prot == CXL11_MULTI && device_prot == CXL20_SINGLE)) begin
      res_prot = CXL11_SINGLE;
    end else if (host_prot == CXL11_MULTI || device_prot == CXL11_MULTI) begin
      res_prot = CXL11_MULTI;
    end else if (host_prot == CXL20_SINGLE) begin
      res_prot = CXL20_SINGLE;
    end else begin
      res_prot = device_prot;
    end
  end

  // Result is loaded at the end of ST_NEG and dropped once back in ST_IDLE
  always_ff @(posedge lclk or negedge reset) begin
    if (!reset) begin
      pl_protocol     <= PROT_NONE;
      pl_protocol_vld <= 1'b0;
    end else if (neg_state == ST_IDLE) begin
      pl_protocol     <= PROT_NONE;
      pl_protocol_vld <= 1'b0;
    end else if (neg_state == ST_NEG) begin
      pl_protocol     <= res_prot;
      pl_protocol_vld <= res_vld;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Port-mode flags

  // All three flags share one register, renegotiation takes priority
  always_ff @(posedge lclk or negedge reset) begin
    if (!reset) begin
      portmode_q <= 1'b0;
    end else if (!renegotiate_n) begin
      portmode_q <= 1'b0;
    end else if (ctl_link_up) begin
      portmode_q <= 1'b1;
    end
  end

  assign pl_inband_pres  = portmode_q;
  assign pl_portmode     = portmode_q;
  assign pl_portmode_val = portmode_q;

endmodule

/* hw/dstrm_insert.sv */
/* Places the local control field at the bottom of every downstream slot until link up.
   DATA_WIDTH must divide evenly into NUM_SLOTS slots wider than the control field. */

`timescale 1ns/1ps

module dstrm_insert #(
  parameter int NUM_SLOTS = 4
) (
  input  logic [lpif_neg_pkg::DATA_WIDTH-1:0] ctrl_dstrm_data,
  input  lpif_neg_pkg::neg_ctl_t              local_ctl,
  input  logic                                negotiation_link_up,
  output logic [lpif_neg_pkg::DATA_WIDTH-1:0] txrx_dstrm_data
);

  import lpif_neg_pkg::*;

  localparam int SLOT_W = DATA_WIDTH / NUM_SLOTS;

  logic [CTL_WIDTH-1:0] ctl_bits;

  assign ctl_bits = local_ctl;

  // Every slot carries the same field, so the remote die can lock onto
  // whichever slot alignment it happens to pick
  for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
    assign txrx_dstrm_data[g*SLOT_W +: CTL_WIDTH] =
      negotiation_link_up ? ctrl_dstrm_data[g*SLOT_W +: CTL_WIDTH] : ctl_bits;

    // Payload above the control field is never touched
    assign txrx_dstrm_data[g*SLOT_W + CTL_WIDTH +: SLOT_W - CTL_WIDTH] =
      ctrl_dstrm_data[g*SLOT_W + CTL_WIDTH +: SLOT_W - CTL_WIDTH];
  end

endmodule

/* hw/lpif_prot_neg.sv */
/* Link-layer protocol negotiation for a die-to-die adapter, 256-bit data path.
   Remote control is always read from slot 0, upstream data passes through untouched. */

`timescale 1ns/1ps

module lpif_prot_neg #(
  parameter lpif_neg_pkg::prot_e LOCAL_PROT = lpif_neg_pkg::CXL11_MULTI,
  parameter bit                  IS_HOST    = 1'b0
) (
  input  logic                                lclk,
  input  logic                                reset,
  input  logic                                ctl_link_up,
  input  logic                                renegotiate_n,
  input  logic [lpif_neg_pkg::DATA_WIDTH-1:0] txrx_ustrm_data,
  input  logic [lpif_neg_pkg::DATA_WIDTH-1:0] ctrl_dstrm_data,
  output logic                                negotiation_link_up,
  output logic [lpif_neg_pkg::DATA_WIDTH-1:0] ctrl_ustrm_data,
  output logic [lpif_neg_pkg::DATA_WIDTH-1:0] txrx_dstrm_data,
  output lpif_neg_pkg::prot_e                 pl_protocol,
  output logic                                pl_protocol_vld,
  output logic                                pl_inband_pres,
  output logic                                pl_portmode,
  output logic                                pl_portmode_val
);

  import lpif_neg_pkg::*;

  neg_ctl_t   rmote_ctl;
  neg_ctl_t   local_ctl;
  neg_state_e neg_state;

  //////////////////////////////////////////////////////////////////////
  // Remote control field from the low slot

  assign rmote_ctl.req  = txrx_ustrm_data[REQ_LOC];
  assign rmote_ctl.ack  = txrx_ustrm_data[ACK_LOC];
  assign rmote_ctl.prot = prot_e'(txrx_ustrm_data[PROT_LOC +: PROT_WIDTH]);

  // The control layer qualifies upstream data with negotiation_link_up
  assign ctrl_ustrm_data = txrx_ustrm_data;

  //////////////////////////////////////////////////////////////////////
  // Negotiation, resolution and downstream insertion

  neg_fsm #(.LOCAL_PROT(LOCAL_PROT)) u_neg_fsm (
    .lclk                (lclk),
    .reset               (reset),
    .ctl_link_up         (ctl_link_up),
    .renegotiate_n       (renegotiate_n),
    .rmote_ctl           (rmote_ctl),
    .local_ctl           (local_ctl),
    .neg_state           (neg_state),
    .negotiation_link_up (negotiation_link_up)
  );

  prot_resolve #(.LOCAL_PROT(LOCAL_PROT), .IS_HOST(IS_HOST)) u_prot_resolve (
    .lclk            (lclk),
    .reset           (reset),
    .neg_state       (neg_state),
    .rmote_prot      (rmote_ctl.prot),
    .renegotiate_n   (renegotiate_n),
    .ctl_link_up     (ctl_link_up),
    .pl_protocol     (pl_protocol),
    .pl_protocol_vld (pl_protocol_vld),
    .pl_inband_pres  (pl_inband_pres),
    .pl_portmode     (pl_portmode),
    .pl_portmode_val (pl_portmode_val)
  );

  dstrm_insert #(.NUM_SLOTS(DATA_WIDTH / SLOT_WIDTH)) u_dstrm_insert (
    .ctrl_dstrm_data     (ctrl_dstrm_data),
    .local_ctl           (local_ctl),
    .negotiation_link_up (negotiation_link_up),
    .txrx_dstrm_data     (txrx_dstrm_data)
  );

endmodule

/* dv/lpif_prot_neg_sva.sv */
/* Handshake and link-up rules of the negotiation FSM, bound into neg_fsm.
   All checks are off while reset is low. */

`timescale 1ns/1ps

module lpif_prot_neg_sva (
  input logic                     lclk,
  input logic                     reset,
  input lpif_neg_pkg::neg_state_e neg_state,
  input lpif_neg_pkg::neg_ctl_t   local_ctl,
  input logic                     negotiation_link_up
);

  import lpif_neg_pkg::*;

  // Our ack is only ever up between ST_W4ACK and ST_QUIET2
  ack_outside_exchange: assert property (@(posedge lclk) disable iff (!reset)
    (neg_state == ST_IDLE || neg_state == ST_DONE) |-> !local_ctl.ack)
    else $error("local ack high outside the exchange");

  neg_single_cycle: assert property (@(posedge lclk) disable iff (!reset)
    (neg_state == ST_NEG) |=> (neg_state == ST_W4NACK))
    else $error("ST_NEG lasted more than one cycle");

  link_up_only_done: assert property (@(posedge lclk) disable iff (!reset)
    negotiation_link_up |-> (neg_state == ST_DONE))
    else $error("negotiation_link_up high outside ST_DONE");

endmodule

bind neg_fsm lpif_prot_neg_sva u_fsm_sva (
  .lclk                (lclk),
  .reset               (reset),
  .neg_state           (neg_state),
  .local_ctl           (local_ctl),
  .negotiation_link_up (negotiation_link_up)
);

/* dv/tb_lpif_prot_neg.sv */
/* Acts as the remote die for 20 negotiations against a local CXL 1.1 multi-port device.
   Remote control sits in upstream slot 0 until link up, then slot 0 carries random payload. */

`timescale 1ns/1ps

module tb_lpif_prot_neg;

  import lpif_neg_pkg::*;

  localparam int NUM_NEG    = 20;
  localparam int NUM_SLOTS  = DATA_WIDTH / SLOT_WIDTH;
  localparam int MAX_CYCLES = NUM_NEG * 80 + 40;

  logic                  lclk;
  logic                  reset;
  logic                  ctl_link_up;
  logic                  renegotiate_n;
  logic [DATA_WIDTH-1:0] txrx_ustrm_data;
  logic [DATA_WIDTH-1:0] ctrl_dstrm_data;
  logic                  negotiation_link_up;
  logic [DATA_WIDTH-1:0] ctrl_ustrm_data;
  logic [DATA_WIDTH-1:0] txrx_dstrm_data;
  prot_e                 pl_protocol;
  logic                  pl_protocol_vld;
  logic                  pl_inband_pres;
  logic                  pl_portmode;
  logic                  pl_portmode_val;

  // Values the remote partner puts on the bus at the next rising edge
  logic                  drv_link_up;
  logic                  drv_reneg_n;
  logic [CTL_WIDTH-1:0]  r_ctl;
  // Normal traffic in slot 0 instead of the remote control field
  logic                  payload_mode;
  // Local req expected in the downstream slots while the link is down
  logic                  exp_req;
  logic [31:0]           lcg_state = 32'ha28db7b4;
  int                    mismatch_count = 0;
  int                    cycle_count = 0;

  lpif_prot_neg #(.LOCAL_PROT(CXL11_MULTI), .IS_HOST(1'b0)) u_lpif_prot_neg (.*);

  initial begin
    lclk = 1'b0;
    forever #50 lclk = ~lclk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] rand_bus();
    logic [DATA_WIDTH-1:0] bus;
    for (int i = 0; i < DATA_WIDTH / 32; i++) begin
      bus[i*32 +: 32] = lcg_next();
    end
    return bus;
  endfunction

  // Resolves host code h against device code d into {valid, protocol}
  function automatic logic [3:0] resolve_model(input logic [2:0] h, input logic [2:0] d);
    if (h < 3'd3 || d < 3'd3) return 4'b0011;
    if (h == 3'd3 || d == 3'd3) return 4'b1011;
    if ((h == 3'd7 && d == 3'd4) || (h == 3'd4 && d == 3'd7)) return 4'b1011;
    if (h == 3'd4 || d == 3'd4) return 4'b1100;
    return (h == 3'd7) ? 4'b1111 : {1'b1, d};
  endfunction

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] expected);
    if (got !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic check_flags(input logic expected);
    check_value("pl_inband_pres, pl_portmode, pl_portmode_val",
                DATA_WIDTH'({pl_inband_pres, pl_portmode, pl_portmode_val}),
                DATA_WIDTH'({3{expected}}));
  endtask

  // Drives one cycle at the rising edge and checks it at the falling edge
  task automatic step();
    logic [DATA_WIDTH-1:0] ustrm;
    logic [DATA_WIDTH-1:0] exp_dstrm;
    ustrm = rand_bus();
    if (!payload_mode) begin
      ustrm[CTL_WIDTH-1:0] = r_ctl;
    end
    @(posedge lclk);
    ctl_link_up     <= drv_link_up;
    renegotiate_n   <= drv_reneg_n;
    txrx_ustrm_data <= ustrm;
    ctrl_dstrm_data <= rand_bus();
    @(negedge lclk);
    exp_dstrm = ctrl_dstrm_data;
    if (!negotiation_link_up) begin
      // Our own code in every slot, with the ack echoing the remote req
      for (int s = 0; s < NUM_SLOTS; s++) begin
        exp_dstrm[s*SLOT_WIDTH +: CTL_WIDTH] =
          {CXL11_MULTI, txrx_ustrm_data[REQ_LOC], exp_req};
      end
    end
    check_value("txrx_dstrm_data", txrx_dstrm_data, exp_dstrm);
    check_value("ctrl_ustrm_data", ctrl_ustrm_data, txrx_ustrm_data);
  endtask

  initial begin
    logic [3:0] exp_res;
    int         waited;
    reset           = 1'b0;
    ctl_link_up     = 1'b0;
    renegotiate_n   = 1'b1;
    txrx_ustrm_data = '0;
    ctrl_dstrm_data = '0;
    drv_link_up     = 1'b0;
    drv_reneg_n     = 1'b1;
    r_ctl           = '0;
    payload_mode    = 1'b0;
    exp_req         = 1'b0;
    repeat (10) @(posedge lclk);
    reset <= 1'b1;
    step();
    check_value("negotiation_link_up, pl_protocol, pl_protocol_vld",
                DATA_WIDTH'({negotiation_link_up, pl_protocol, pl_protocol_vld}), '0);
    check_flags(1'b0);
    drv_link_up = 1'b1;
    step();
    check_flags(1'b0);
    exp_req = 1'b1;
    step();
    check_flags(1'b1);
    for (int n = 0; n < NUM_NEG; n++) begin
      r_ctl = {3'(lcg_next() >> 29), 2'b00};
      repeat (lcg_next() >> 28) step();
      // Remote requests and acknowledges together
      r_ctl[ACK_LOC:REQ_LOC] = 2'b11;
      // The edge that samples both high enters ST_NEG, which lasts one cycle
      step();
      step();
      exp_req = 1'b0;
      step();
      check_value("local ack", DATA_WIDTH'(txrx_dstrm_data[ACK_LOC]), DATA_WIDTH'(1));
      exp_res = resolve_model(r_ctl[PROT_LOC +: PROT_WIDTH], 3'd4);
      repeat (lcg_next() >> 28) step();
      r_ctl[ACK_LOC:REQ_LOC] = 2'b00;
      step();
      waited = 0;
      do begin
        step();
        waited++;
      end while (!negotiation_link_up && waited < 20);
      check_value("cycles to negotiation_link_up", DATA_WIDTH'(waited), DATA_WIDTH'(3));
      check_value("pl_protocol_vld, pl_protocol",
                  DATA_WIDTH'({pl_protocol_vld, pl_protocol}), DATA_WIDTH'(exp_res));
      // Upstream slot 0 is ordinary traffic once the link is up
      payload_mode = 1'b1;
      repeat (lcg_next() >> 30) step();
      if (n < NUM_NEG - 1) begin
        // Hold renegotiate_n low for two edges so the idle clear is visible
        drv_reneg_n = 1'b0;
        step();
        payload_mode = 1'b0;
        step();
        check_value("negotiation_link_up", DATA_WIDTH'(negotiation_link_up), '0);
        check_flags(1'b0);
        step();
        check_value("pl_protocol_vld, pl_protocol",
                    DATA_WIDTH'({pl_protocol_vld, pl_protocol}), '0);
        drv_reneg_n = 1'b1;
        step();
        check_flags(1'b0);
        exp_req = 1'b1;
        step();
        check_flags(1'b1);
      end
    end
    $display("Negotiations: %0d, mismatches: %0d", NUM_NEG, mismatch_count);
    if (mismatch_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Cycle counter bounds the whole run
  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge lclk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* compile.f */
common/lpif_neg_pkg.sv
hw/neg_fsm.sv
hw/prot_resolve.sv
hw/dstrm_insert.sv
hw/lpif_prot_neg.sv
dv/lpif_prot_neg_sva.sv
dv/tb_lpif_prot_neg.sv

/* run.sh */
#!/bin/sh
# Builds the negotiation testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_lpif_prot_neg -f compile.f -o sim_tb_lpif_prot_neg

status=0
./obj_dir/sim_tb_lpif_prot_neg > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
